/* rs_defs.svh */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// function units, one reservation station row each
`define NUM_FU 4

// width of the index selecting a function unit
`define FU_IDX_BITS $clog2(`NUM_FU)

// physical register tag width
`define TAG_BITS 5

// physical register count covered by the scoreboard
`define NUM_TAGS (1 << `TAG_BITS)

`endif

/* rs_types_pkg.sv */
`include "rs_defs.svh"

package rs_types_pkg;

	// physical register name after rename
	typedef logic [`TAG_BITS-1:0] phys_tag_t;

	// selects one function unit and its row
	typedef logic [`FU_IDX_BITS-1:0] fu_idx_t;

	// operation kind, only latency depends on it
	typedef enum logic [2:0]
	{
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_LOAD = 3'd3,
		OP_MUL  = 3'd4
	} opcode_t;

	// one reservation station entry
	typedef struct packed
	{
		// entry holds a waiting instruction
		logic      busy;
		opcode_t   opcode;
		// result tag, broadcast on completion
		phys_tag_t dest_tag;
		// first operand and its ready flag
		phys_tag_t src1_tag;
		logic      src1_ready;
		// second operand and its ready flag
		phys_tag_t src2_tag;
		logic      src2_ready;
	} rs_row_t;

endpackage

/* rs_bus_pkg.sv */
package rs_bus_pkg;

	// decoded, renamed instruction from dispatch
	typedef struct packed
	{
		rs_types_pkg::opcode_t   opcode;
		// target unit, also the row index
		rs_types_pkg::fu_idx_t   fu;
		rs_types_pkg::phys_tag_t dest_tag;
		rs_types_pkg::phys_tag_t src1_tag;
		rs_types_pkg::phys_tag_t src2_tag;
		// filled in by the scoreboard
		logic                    src1_ready;
		logic                    src2_ready;
	} dispatch_pkt_t;

	// what a unit needs once a row issues
	typedef struct packed
	{
		rs_types_pkg::opcode_t   opcode;
		rs_types_pkg::phys_tag_t dest_tag;
	} issue_pkt_t;

	// common data bus broadcast
	typedef struct packed
	{
		// one cycle pulse per completion
		logic                    valid;
		// unit that produced the result
		rs_types_pkg::fu_idx_t   fu;
		rs_types_pkg::phys_tag_t tag;
	} cdb_pkt_t;

endpackage

/* dispatch_stage.sv */
`include "rs_defs.svh"

module dispatch_stage
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_valid,
	input  rs_bus_pkg::dispatch_pkt_t dispatch_in,
	input  logic [`NUM_FU-1:0]        row_busy,
	input  rs_bus_pkg::cdb_pkt_t      cdb,
	output logic                      stall,
	output logic                      dispatch_write,
	output rs_bus_pkg::dispatch_pkt_t dispatch_out
);

	// one bit per physical register, set while its producer is in flight
	logic [`NUM_TAGS-1:0] pending;

	// operand readiness before and after the cdb bypass
	logic src1_pending;
	logic src2_pending;
	logic src1_on_cdb;
	logic src2_on_cdb;

	// target row still holds an older instruction
	logic target_busy;

	assign target_busy = row_busy[dispatch_in.fu];

	// only a presented instruction can stall
	assign stall = dispatch_valid && target_busy;

	// accepted this edge, row gets written at the same edge
	assign dispatch_write = dispatch_valid && !target_busy;

	// scoreboard lookup
	assign src1_pending = pending[dispatch_in.src1_tag];
	assign src2_pending = pending[dispatch_in.src2_tag];

	// producer finishing right now counts as ready
	assign src1_on_cdb = cdb.valid && (cdb.tag == dispatch_in.src1_tag);
	assign src2_on_cdb = cdb.valid && (cdb.tag == dispatch_in.src2_tag);

	always_comb
	begin
		dispatch_out = dispatch_in;
		dispatch_out.src1_ready = !src1_pending || src1_on_cdb;
		dispatch_out.src2_ready = !src2_pending || src2_on_cdb;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// every register holds a committed value after reset
			pending <= '0;
		end
		else
		begin
			// completion clears the tag
			if (cdb.valid)
				pending[cdb.tag] <= 1'b0;
			// new producer marks its result as not yet available
			// set wins, a fresh dest tag is never the one on the cdb
			if (dispatch_write)
				pending[dispatch_in.dest_tag] <= 1'b1;
		end
	end

	// a broadcast tag must belong to an accepted, unfinished instruction
	cdb_tag_was_pending: assert property (
		@(posedge clock) disable iff (reset)
		cdb.valid |-> pending[cdb.tag]
	);

endmodule

/* rs.sv */
`include "rs_defs.svh"

module rs
(
	input  logic                                    clock,
	input  logic                                    reset,
	input  logic                                    dispatch_write,
	input  rs_bus_pkg::dispatch_pkt_t               dispatch_in,
	input  rs_bus_pkg::cdb_pkt_t                    cdb,
	input  logic [`NUM_FU-1:0]                      fu_busy,
	output logic [`NUM_FU-1:0]                      row_busy,
	output logic [`NUM_FU-1:0]                      issue,
	output rs_bus_pkg::issue_pkt_t [`NUM_FU-1:0]    issue_out
);

	// one row per function unit
	rs_types_pkg::rs_row_t rows [`NUM_FU];

	// rows targeted by this cycle's dispatch
	logic [`NUM_FU-1:0] write_sel;

	// rows with both operands in hand and an idle unit
	logic [`NUM_FU-1:0] can_issue;

	// cdb tag matches per row and operand
	logic [`NUM_FU-1:0] wake1;
	logic [`NUM_FU-1:0] wake2;

	always_comb
	begin
		for (int i = 0; i < `NUM_FU; i++)
		begin
			row_busy[i] = rows[i].busy;
			// decode of the target unit
			write_sel[i] = dispatch_write &&
				(dispatch_in.fu == rs_types_pkg::fu_idx_t'(i));
			// cam compare against the broadcast tag
			wake1[i] = cdb.valid && (rows[i].src1_tag == cdb.tag);
			wake2[i] = cdb.valid && (rows[i].src2_tag == cdb.tag);
			// operands woken this cycle wait for the next one
			can_issue[i] = rows[i].busy && rows[i].src1_ready &&
				rows[i].src2_ready && !fu_busy[i];
		end
	end

	// row table
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (reset)
			begin
				rows[i].busy <= 1'b0;
			end
			else if (write_sel[i])
			begin
				// dispatch already applied the cdb bypass
				rows[i].busy       <= 1'b1;
				rows[i].opcode     <= dispatch_in.opcode;
				rows[i].dest_tag   <= dispatch_in.dest_tag;
				rows[i].src1_tag   <= dispatch_in.src1_tag;
				rows[i].src1_ready <= dispatch_in.src1_ready;
				rows[i].src2_tag   <= dispatch_in.src2_tag;
				rows[i].src2_ready <= dispatch_in.src2_ready;
			end
			else if (can_issue[i])
			begin
				// leaves for the unit, row is free next cycle
				rows[i].busy <= 1'b0;
			end
			else
			begin
				// wakeup, harmless on a free row
				if (wake1[i])
					rows[i].src1_ready <= 1'b1;
				if (wake2[i])
					rows[i].src2_ready <= 1'b1;
			end
		end
	end

	// registered issue strobe, one cycle wide
	always_ff @(posedge clock)
	begin
		if (reset)
			issue <= '0;
		else
			issue <= can_issue;
	end

	// issue payload, only sampled under the strobe
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (can_issue[i])
			begin
				issue_out[i].opcode   <= rows[i].opcode;
				issue_out[i].dest_tag <= rows[i].dest_tag;
			end
		end
	end

	// dispatch must hold back while the target row is occupied
	no_write_to_busy_row: assert property (
		@(posedge clock) disable iff (reset)
		dispatch_write |-> !rows[dispatch_in.fu].busy
	);

endmodule

/* completion_unit.sv */
`include "rs_defs.svh"

module completion_unit
(
	input  logic                                    clock,
	input  logic                                    reset,
	input  logic [`NUM_FU-1:0]                      issue,
	input  rs_bus_pkg::issue_pkt_t [`NUM_FU-1:0]    issue_in,
	output logic [`NUM_FU-1:0]                      fu_busy,
	output rs_bus_pkg::cdb_pkt_t                    cdb
);

	// cycles left before a result may request the bus
	logic [1:0] count [`NUM_FU];

	// result tag held until granted
	rs_types_pkg::phys_tag_t tag [`NUM_FU];

	// bus requests and the single winner
	logic [`NUM_FU-1:0]      req;
	logic [`NUM_FU-1:0]      grant;
	rs_types_pkg::fu_idx_t   grant_idx;
	rs_types_pkg::phys_tag_t grant_tag;

	// execution latency minus one, the request cycle itself counts
	function automatic logic [1:0] latency(input rs_types_pkg::opcode_t op);
		case (op)
			rs_types_pkg::OP_LOAD: latency = 2'd1;
			rs_types_pkg::OP_MUL:  latency = 2'd2;
			default:               latency = 2'd0;
		endcase
	endfunction

	always_comb
	begin
		for (int i = 0; i < `NUM_FU; i++)
			req[i] = fu_busy[i] && (count[i] == 2'd0);
	end

	// fixed priority, lowest unit index wins
	always_comb
	begin
		grant     = '0;
		grant_idx = '0;
		grant_tag = '0;
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (req[i] && (grant == '0))
			begin
				grant[i]  = 1'b1;
				grant_idx = rs_types_pkg::fu_idx_t'(i);
				grant_tag = tag[i];
			end
		end
	end

	// unit state
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `NUM_FU; i++)
		begin
			if (reset)
			begin
				fu_busy[i] <= 1'b0;
			end
			else if (issue[i])
			begin
				fu_busy[i] <= 1'b1;
				count[i]   <= latency(issue_in[i].opcode);
				tag[i]     <= issue_in[i].dest_tag;
			end
			else if (grant[i])
			begin
				// result leaves on the bus, unit free again
				fu_busy[i] <= 1'b0;
			end
			else if (fu_busy[i] && (count[i] != 2'd0))
			begin
				count[i] <= count[i] - 2'd1;
			end
			// a losing requester just holds its result
		end
	end

	// registered bus
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			cdb.valid <= 1'b0;
		end
		else
		begin
			cdb.valid <= |grant;
			cdb.fu    <= grant_idx;
			cdb.tag   <= grant_tag;
		end
	end

	for (genvar g = 0; g < `NUM_FU; g++)
	begin : g_issue_chk
		// the station only issues to an idle unit
		no_issue_to_busy_unit: assert property (
			@(posedge clock) disable iff (reset)
			issue[g] |-> !fu_busy[g]
		);
	end

endmodule

/* rs_top.sv */
`include "rs_defs.svh"

module rs_top
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      dispatch_valid,
	input  rs_bus_pkg::dispatch_pkt_t dispatch_in,
	output logic                      stall,
	output rs_bus_pkg::cdb_pkt_t      cdb
);

	// dispatch to station
	logic                      dispatch_write;
	rs_bus_pkg::dispatch_pkt_t dispatch_pkt;

	// station back to dispatch
	logic [`NUM_FU-1:0] row_busy;

	// station to units and back
	logic [`NUM_FU-1:0]                   issue;
	rs_bus_pkg::issue_pkt_t [`NUM_FU-1:0] issue_pkt;
	logic [`NUM_FU-1:0]                   fu_busy;

	// scoreboard, ready marking, stall
	dispatch_stage dispatch_i
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_in    (dispatch_in),
		.row_busy       (row_busy),
		.cdb            (cdb),
		.stall          (stall),
		.dispatch_write (dispatch_write),
		.dispatch_out   (dispatch_pkt)
	);

	// reservation station
	rs rs_i
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_write (dispatch_write),
		.dispatch_in    (dispatch_pkt),
		.cdb            (cdb),
		.fu_busy        (fu_busy),
		.row_busy       (row_busy),
		.issue          (issue),
		.issue_out      (issue_pkt)
	);

	// latency model and cdb arbiter
	completion_unit completion_i
	(
		.clock    (clock),
		.reset    (reset),
		.issue    (issue),
		.issue_in (issue_pkt),
		.fu_busy  (fu_busy),
		.cdb      (cdb)
	);

endmodule

/* rs_tb.sv */
`include "rs_defs.svh"

module rs_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// run length and wait limits in cycles
	localparam int NUM_INSTR   = 200;
	localparam int HOLD_LIMIT  = 100;
	localparam int DRAIN_LIMIT = 400;

	logic                      clock;
	logic                      reset;
	logic                      dispatch_valid;
	rs_bus_pkg::dispatch_pkt_t dispatch_in;
	logic                      stall;
	rs_bus_pkg::cdb_pkt_t      cdb;

	integer seed;
	// advances at each falling edge
	int     cyc;

	// model state, indexed by destination tag
	logic                  pending [`NUM_TAGS];
	rs_types_pkg::opcode_t op_of [`NUM_TAGS];
	rs_types_pkg::fu_idx_t fu_of [`NUM_TAGS];
	int                    accept_at [`NUM_TAGS];
	// producers each in-flight instruction still waits for
	logic [`NUM_TAGS-1:0]  deps [`NUM_TAGS];
	// accepted, not yet on the cdb
	int                    outstanding [`NUM_FU];
	int                    completed;

	rs_bus_pkg::dispatch_pkt_t cur;
	logic                      holding;
	int                        hold_cycles;
	int                        gap_left;
	int                        sent;
	int                        drain_cycles;

	always
		#50 clock = ~clock;

	rs_top dut_i
	(
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_in    (dispatch_in),
		.stall          (stall),
		.cdb            (cdb)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[ERROR] %0d ns: %s", $time, msg));
	endtask

	// execution cycles per opcode
	function automatic int exec_cycles(input rs_types_pkg::opcode_t op);
		case (op)
			rs_types_pkg::OP_LOAD: return 2;
			rs_types_pkg::OP_MUL:  return 3;
			default:               return 1;
		endcase
	endfunction

	task automatic check_stall(input logic expected, input logic got);
		if (got !== expected)
			report_mismatch($sformatf("stall is %b, expected %b", got, expected));
	endtask

	// a valid broadcast must retire a known, unblocked, old enough tag
	task automatic check_cdb(input rs_bus_pkg::cdb_pkt_t got);
		rs_types_pkg::phys_tag_t t;
		t = got.tag;
		if (got.valid === 1'b1)
		begin
			if (pending[t] !== 1'b1)
				report_mismatch($sformatf("cdb tag %0d is not in flight", t));
			else if (got.fu !== fu_of[t])
				report_mismatch($sformatf("cdb tag %0d from unit %0d, sent to %0d",
					t, got.fu, fu_of[t]));
			else if (deps[t] != '0)
				report_mismatch($sformatf("tag %0d done before sources %h", t, deps[t]));
			else if (cyc - accept_at[t] < exec_cycles(op_of[t]) + 2)
				report_mismatch($sformatf("tag %0d done after only %0d cycles",
					t, cyc - accept_at[t]));
			else
			begin
				pending[t] = 1'b0;
				outstanding[fu_of[t]]--;
				completed++;
				// wakes every consumer of this producer
				for (int k = 0; k < `NUM_TAGS; k++)
					deps[k][t] = 1'b0;
			end
		end
		else if (got.valid !== 1'b0)
			report_mismatch("cdb valid is unknown");
	endtask

	task automatic make_instr(output rs_bus_pkg::dispatch_pkt_t pkt);
		int                      start;
		rs_types_pkg::phys_tag_t t;
		logic                    found;
		pkt          = '0;
		pkt.opcode   = rs_types_pkg::opcode_t'($unsigned($random(seed)) % 5);
		pkt.fu       = rs_types_pkg::fu_idx_t'($unsigned($random(seed)) % `NUM_FU);
		pkt.src1_tag = rs_types_pkg::phys_tag_t'($random(seed));
		pkt.src2_tag = rs_types_pkg::phys_tag_t'($random(seed));
		// free dest, skipping the tag on the bus right now
		start = $unsigned($random(seed)) % `NUM_TAGS;
		found = 1'b0;
		for (int k = 0; k < `NUM_TAGS; k++)
		begin
			t = rs_types_pkg::phys_tag_t'(start + k);
			if (!found && !pending[t] && !(cdb.valid && cdb.tag == t))
			begin
				pkt.dest_tag = t;
				found        = 1'b1;
			end
		end
		if (!found)
			abort_run("no free destination tag left in the model");
	endtask

	task automatic note_accepted(input rs_bus_pkg::dispatch_pkt_t pkt);
		rs_types_pkg::phys_tag_t d;
		d       = pkt.dest_tag;
		deps[d] = '0;
		// sources still in flight at acceptance
		if (pending[pkt.src1_tag])
			deps[d][pkt.src1_tag] = 1'b1;
		if (pending[pkt.src2_tag])
			deps[d][pkt.src2_tag] = 1'b1;
		pending[d]   = 1'b1;
		op_of[d]     = pkt.opcode;
		fu_of[d]     = pkt.fu;
		// row written at the coming rising edge
		accept_at[d] = cyc + 1;
		outstanding[pkt.fu]++;
	endtask

	initial
	begin
		seed           = 32'h23c7;
		clock          = 1'b0;
		reset          = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_in    = '0;
		cur            = '0;
		holding        = 1'b0;
		cyc            = 0;
		completed      = 0;
		sent           = 0;
		gap_left       = 0;
		hold_cycles    = 0;
		for (int k = 0; k < `NUM_TAGS; k++)
		begin
			pending[k]   = 1'b0;
			deps[k]      = '0;
			accept_at[k] = 0;
			op_of[k]     = rs_types_pkg::OP_ADD;
			fu_of[k]     = '0;
		end
		for (int u = 0; u < `NUM_FU; u++)
			outstanding[u] = 0;
		// three reset edges, bus and stall quiet
		repeat (3)
		begin
			@(negedge clock);
			cyc++;
			check_cdb(cdb);
			check_stall(1'b0, stall);
		end
		reset = 1'b0;
		while (sent < NUM_INSTR)
		begin
			@(negedge clock);
			cyc++;
			check_cdb(cdb);
			if (!holding && gap_left > 0)
				gap_left--;
			else if (!holding)
			begin
				make_instr(cur);
				holding     = 1'b1;
				hold_cycles = 0;
			end
			dispatch_valid = holding;
			dispatch_in    = cur;
			// stall settles well before the rising edge
			#10;
			if (!holding || outstanding[cur.fu] == 0)
				check_stall(1'b0, stall);
			if (holding && stall === 1'b0)
			begin
				note_accepted(cur);
				holding  = 1'b0;
				sent++;
				gap_left = $unsigned($random(seed)) % 4;
			end
			else if (holding && stall === 1'b1)
			begin
				hold_cycles++;
				if (hold_cycles > HOLD_LIMIT)
					abort_run($sformatf("timeout: tag %0d stalled too long", cur.dest_tag));
			end
			else if (holding)
				report_mismatch("stall is unknown");
		end
		// drain, every accepted tag must come back
		drain_cycles = 0;
		while (completed < NUM_INSTR)
		begin
			@(negedge clock);
			cyc++;
			check_cdb(cdb);
			dispatch_valid = 1'b0;
			drain_cycles++;
			if (completed < NUM_INSTR && drain_cycles > DRAIN_LIMIT)
				abort_run($sformatf("timeout: %0d results missing", NUM_INSTR - completed));
		end
		// nothing more may show up on the bus
		repeat (5)
		begin
			@(negedge clock);
			cyc++;
			check_cdb(cdb);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
rs_types_pkg.sv
rs_bus_pkg.sv
dispatch_stage.sv
rs.sv
completion_unit.sv
rs_top.sv
rs_tb.sv
